// ==== Makefile ====
TOOL   = verilator
FLAGS  = --binary --timing --assert
TOP    = sms_loader_tb
FLIST  = tb.f
LOG    = sim.log
OBJDIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

$(OBJDIR)/V$(TOP): $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/sms_loader_asserts.sv ====
module sms_loader_asserts (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic rom_req,
	input logic dl_wait,
	input logic bk_pending,
	input logic bk_state
);

	timeunit 1ns;
	timeprecision 100ps;

	// One SD direction at a time
	sd_dir_excl: assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else $error("SD read and write requested together");

	rom_req_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(rom_req) |-> dl_wait)
		else $error("ROM request toggled outside a wait window");

	pending_in_seq: assert property (@(posedge clk_sys) disable iff (reset)
		bk_state |-> !bk_pending)
		else $error("Backup pending flag high during a sequence");

endmodule

bind sms_loader_top sms_loader_asserts asserts_i (.*);

// ==== dv/sms_loader_tb.sv ====
module sms_loader_tb import sms_loader_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int K_CART  = 0;
	localparam int K_CHEAT = 1;
	localparam int K_LOAD  = 2;
	localparam int K_SAVE  = 3;
	localparam int K_AUTO  = 4;

	typedef struct packed {
		int         kind;
		int         len;      // Bytes downloaded or core writes
		logic [7:0] index;
		logic       exp_sz;
		logic       exp_gg;
		int         exp_sectors;
	} op_t;

	localparam op_t OPS [6] = '{
		'{K_CART, 1024, 8'd2, 1'b0, 1'b1, 0},
		'{K_CART, 1536, 8'd1, 1'b1, 1'b0, 0},    // Carries a header
		'{K_CHEAT, 16, 8'hFF, 1'b0, 1'b0, 0},
		'{K_LOAD, 512, 8'd1, 1'b0, 1'b0, 64},
		'{K_SAVE, 512, 8'd0, 1'b0, 1'b0, 64},
		'{K_AUTO, 1, 8'd0, 1'b0, 1'b0, 64}
	};

	localparam logic [ROM_AW-1:0] RD_ADDRS [6] = '{
		22'h0, 22'h1FF, 22'h200, 22'h3FF, 22'h5A5, 22'h2ABCD
	};

	logic clk_sys = 1'b0;
	logic reset = 1'b1;
	dl_bus_t dl;
	logic rom_ack;
	logic [ROM_AW-1:0] core_rom_addr;
	nv_port_t nv;
	sd_buf_t sd;
	logic bk_load, bk_save, autosave, osd_open;
	logic img_mounted, img_readonly, img_size_nz;

	logic dl_wait, rom_req, cheat_valid, ce_cpu, ce_vdp, ce_pix, ce_sp;
	logic [ROM_AW-1:0] rom_addr, rom_rd_addr;
	logic [7:0] rom_data, nv_q, sd_buff_din;
	cart_info_t cart;
	cheat_code_t cheat;
	logic [LBA_W-1:0] sd_lba;
	logic sd_rd, sd_wr, bk_state, bk_loading, bk_pending, core_reset;

	logic [31:0] lfsr_state = 32'hb105d54a;
	logic [7:0] sd_img [2**NVRAM_AW];
	logic [7:0] shadow [2**NVRAM_AW];
	logic [7:0] cheat_bytes [16];
	int errors = 0;
	int checks = 0;
	int rom_wr_cnt, sd_sectors, sd_reads, sd_writes, valid_cnt;

	sms_loader_top dut_i (.*);

	always #20 clk_sys = ~clk_sys;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (b)
				lfsr_state = lfsr_state ^ 32'h80200003;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic logic [7:0] cart_byte(input int a);
		return a[7:0] ^ {a[10:8], 5'h13};
	endfunction

	task automatic check_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("mismatch %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	// ==================================================
	// Memory and SD models
	// ==================================================
	always begin
		int delay;
		tick();
		if (rom_req != rom_ack) begin
			delay = int'(lfsr_bits(3));    // 0 to 7 cycles
			repeat (delay) tick();
			check_eq("rom write addr", 128'(rom_wr_cnt), 128'(rom_addr));
			check_eq("rom write data", 128'(cart_byte(rom_wr_cnt)), 128'(rom_data));
			rom_ack = rom_req;
			rom_wr_cnt++;
		end
	end

	always begin
		logic is_rd;
		logic [LBA_W-1:0] lba;
		tick();
		if (sd_rd || sd_wr) begin
			is_rd = sd_rd;
			lba = sd_lba;
			check_eq("sector number", 128'(sd_sectors), 128'(lba));
			sd.ack = 1'b1;
			for (int i = 0; i < 512; i++) begin
				sd.buff_addr = 9'(i);
				sd.buff_wr = is_rd;
				sd.buff_dout = sd_img[{lba, 9'(i)}];
				tick();
				if (!is_rd)
					check_eq("save byte", 128'(shadow[{lba, 9'(i)}]), 128'(sd_buff_din));
			end
			sd.ack = 1'b0;
			sd.buff_wr = 1'b0;
			sd_sectors++;
			if (is_rd)
				sd_reads++;
			else
				sd_writes++;
		end
	end

	always @(posedge clk_sys)
		if (cheat_valid)
			valid_cnt++;

	// ==================================================
	// Stimulus tasks
	// ==================================================
	task automatic run_download(input logic [7:0] idx, input int len);
		rom_wr_cnt = 0;
		dl.index = idx;
		dl.download = 1'b1;
		tick();
		for (int a = 0; a < len; a++) begin
			dl.addr = 25'(a);
			dl.data = (idx == CHEAT_INDEX) ? cheat_bytes[a % 16] : cart_byte(a);
			dl.wr = 1'b1;
			tick();
			dl.wr = 1'b0;
			check_eq("dl_wait", 128'(idx != CHEAT_INDEX), 128'(dl_wait));
			while (dl_wait)
				tick();
		end
		dl.addr = 25'(len);    // Host leaves the byte count behind
		dl.download = 1'b0;
		repeat (3) tick();
	endtask

	task automatic core_write(input logic [NVRAM_AW-1:0] a, input logic [7:0] d);
		nv.addr = a;
		nv.d = d;
		nv.we = 1'b1;
		tick();
		nv.we = 1'b0;
		shadow[a] = d;
	endtask

	task automatic wait_seq(input logic watch_reset);
		int n;
		n = 0;
		while (!bk_state && n < 40) begin
			tick();
			n++;
		end
		check_true(bk_state, "backup sequence did not start");
		check_eq("bk_loading", 128'(watch_reset), 128'(bk_loading));
		check_eq("pending at sequence start", 128'(0), 128'(bk_pending));
		while (bk_state) begin
			if (watch_reset && bk_loading)
				check_true(core_reset, "core_reset dropped while loading save RAM");
			tick();
		end
	endtask

	task automatic check_cart(input op_t op);
		logic [ROM_AW-1:0] m, m512, exp_rd;
		m = '0;
		m512 = '0;
		for (int a = 0; a < op.len; a++) begin
			m = (a == 0) ? '0 : m | ROM_AW'(a);
			m512 = (a == HDR_BYTES) ? '0 : m512 | ROM_AW'(a - HDR_BYTES);
		end
		check_eq("rom write count", 128'(op.len), 128'(rom_wr_cnt));
		check_eq("mask", 128'(m), 128'(cart.mask));
		check_eq("mask512", 128'(m512), 128'(cart.mask512));
		check_eq("sz512", 128'(op.exp_sz), 128'(cart.sz512));
		check_eq("gg", 128'(op.exp_gg), 128'(cart.gg));
		foreach (RD_ADDRS[i]) begin
			core_rom_addr = RD_ADDRS[i];
			exp_rd = op.exp_sz ? (RD_ADDRS[i] + ROM_AW'(HDR_BYTES)) & m512 : RD_ADDRS[i] & m;
			tick();
			check_eq("rom read addr", 128'(exp_rd), 128'(rom_rd_addr));
		end
	endtask

	task automatic check_cheat();
		cheat_code_t exp;
		exp = '0;
		for (int k = 0; k < 16; k++) begin
			case (k / 4)
				0: exp.flags[(k % 4) * 8 +: 8] = cheat_bytes[k];
				1: exp.address[(k % 4) * 8 +: 8] = cheat_bytes[k];
				2: exp.compare[(k % 4) * 8 +: 8] = cheat_bytes[k];
				default: exp.replace[(k % 4) * 8 +: 8] = cheat_bytes[k];
			endcase
		end
		check_eq("cheat flags", 128'(exp.flags), 128'(cheat.flags));
		check_eq("cheat address", 128'(exp.address), 128'(cheat.address));
		check_eq("cheat compare", 128'(exp.compare), 128'(cheat.compare));
		check_eq("cheat replace", 128'(exp.replace), 128'(cheat.replace));
		check_eq("cheat valid pulses", 128'(1), 128'(valid_cnt));
	endtask

	task automatic check_ce();
		int vdp, pix, cpu, sp, first_vdp;
		first_vdp = -1;
		for (int w = 0; w < 2; w++) begin
			vdp = 0;
			pix = 0;
			cpu = 0;
			sp = 0;
			for (int k = 0; k < CE_PERIOD; k++) begin
				tick();
				if (ce_vdp && first_vdp < 0)
					first_vdp = k;
				vdp += int'(ce_vdp);
				pix += int'(ce_pix);
				cpu += int'(ce_cpu);
				sp += int'(ce_sp);
			end
			check_eq("ce_vdp count", 128'(6), 128'(vdp));
			check_eq("ce_pix count", 128'(3), 128'(pix));
			check_eq("ce_cpu count", 128'(2), 128'(cpu));
			check_eq("ce_sp count", 128'(15), 128'(sp));
		end
		check_eq("first ce_vdp", 128'(4), 128'(first_vdp));
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int total;
		total = 0;
		foreach (OPS[i])
			total += OPS[i].len;
		repeat (total * 20 + 70000) @(posedge clk_sys);
		$display("Watchdog expired before the table finished");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		dl = '0;
		rom_ack = 1'b0;
		core_rom_addr = '0;
		nv = '0;
		sd = '0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		autosave = 1'b0;
		osd_open = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nz = 1'b0;
		valid_cnt = 0;
		for (int i = 0; i < 2**NVRAM_AW; i++)
			sd_img[i] = 8'(lfsr_bits(8));
		foreach (cheat_bytes[i])
			cheat_bytes[i] = 8'(lfsr_bits(8));
		repeat (10) @(posedge clk_sys);
		#1 reset = 1'b0;
		check_ce();

		foreach (OPS[i]) begin
			sd_sectors = 0;
			sd_reads = 0;
			sd_writes = 0;
			case (OPS[i].kind)
				K_CART: begin
					run_download(OPS[i].index, OPS[i].len);
					check_cart(OPS[i]);
				end
				K_CHEAT: begin
					valid_cnt = 0;
					run_download(OPS[i].index, OPS[i].len);
					check_cheat();
				end
				K_LOAD: begin
					img_mounted = 1'b1;
					img_size_nz = 1'b1;
					run_download(OPS[i].index, OPS[i].len);
					wait_seq(1'b1);
					check_eq("load sectors", 128'(OPS[i].exp_sectors), 128'(sd_reads));
					check_true(!core_reset, "core_reset still high after the load");
					for (int a = 0; a < 2**NVRAM_AW; a++)
						shadow[a] = sd_img[a];
					for (int a = 0; a < 2**NVRAM_AW; a += 97) begin
						nv.addr = NVRAM_AW'(a);
						tick();
						check_eq("nvram readback", 128'(sd_img[a]), 128'(nv_q));
					end
				end
				K_SAVE: begin
					for (int n = 0; n < OPS[i].len; n++)
						core_write(NVRAM_AW'(lfsr_bits(NVRAM_AW)), 8'(lfsr_bits(8)));
					check_true(bk_pending, "core writes did not raise bk_pending");
					bk_save = 1'b1;
					tick();
					bk_save = 1'b0;
					wait_seq(1'b0);
					check_eq("save sectors", 128'(OPS[i].exp_sectors), 128'(sd_writes));
				end
				default: begin
					core_write(NVRAM_AW'(lfsr_bits(NVRAM_AW)), 8'(lfsr_bits(8)));
					check_eq("pending after write", 128'(1), 128'(bk_pending));
					autosave = 1'b1;
					osd_open = 1'b1;
					wait_seq(1'b0);
					check_eq("autosave sectors", 128'(OPS[i].exp_sectors), 128'(sd_writes));
					autosave = 1'b0;
					osd_open = 1'b0;
				end
			endcase
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== src/backup_ram_ctrl.sv ====
module backup_ram_ctrl import sms_loader_pkg::*; (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             cart_dl,
	input  nv_port_t         nv,
	output logic [7:0]       nv_q,
	input  sd_buf_t          sd,
	output logic [LBA_W-1:0] sd_lba,
	output logic             sd_rd,
	output logic             sd_wr,
	output logic [7:0]       sd_buff_din,
	input  logic             bk_load,
	input  logic             bk_save,
	input  logic             autosave,
	input  logic             osd_open,
	input  logic             img_mounted,
	input  logic             img_readonly,
	input  logic             img_size_nz,
	output logic             bk_state,
	output logic             bk_loading,
	output logic             bk_pending
);

	logic cart_dl_q, ack_q, load_q, save_q;
	logic bk_ena;
	logic save_req, load_start, save_start, auto_load;
	logic start, start_load;

	nvram_dpram nvram_i (
		.clk_sys (clk_sys),
		.a_addr  (nv.addr),
		.a_we    (nv.we),
		.a_d     (nv.d),
		.a_q     (nv_q),
		.b_addr  ({sd_lba, sd.buff_addr}),
		.b_we    (sd.buff_wr & sd.ack),
		.b_d     (sd.buff_dout),
		.b_q     (sd_buff_din)
	);

	// ==================================================
	// Triggers
	// ==================================================
	assign save_req   = bk_save | (bk_pending & osd_open & autosave);
	assign load_start = bk_load & ~load_q;
	assign save_start = save_req & ~save_q;
	assign auto_load  = cart_dl_q & ~cart_dl & img_size_nz;    // Image just loaded
	assign start      = bk_ena & ~bk_state & (load_start | save_start | auto_load);
	assign start_load = load_start | auto_load;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q  <= 1'b0;
			ack_q      <= 1'b0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			ack_q     <= sd.ack;
			load_q    <= bk_load;
			save_q    <= save_req;

			if (cart_dl && !cart_dl_q)
				bk_ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1;    // Save file is mounted by the end of the download

			if (start || bk_state)
				bk_pending <= 1'b0;
			else if (bk_ena && !osd_open && nv.we)
				bk_pending <= 1'b1;
		end
	end

	// ==================================================
	// Sector sequence
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_state   <= 1'b0;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			if (sd.ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (start) begin
				bk_state   <= 1'b1;
				bk_loading <= start_load;
				sd_lba     <= '0;
				sd_rd      <= start_load;
				sd_wr      <= ~start_load;
			end else if (bk_state && ack_q && !sd.ack) begin
				if (sd_lba == LBA_W'(BK_SECTORS - 1)) begin
					bk_state   <= 1'b0;    // Last sector done
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

// ==== src/cart_loader.sv ====
module cart_loader import sms_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  dl_bus_t           dl,
	input  logic              cart_sel,      // Cartridge download in progress
	output logic              dl_wait,
	output logic              rom_req,
	output logic [ROM_AW-1:0] rom_addr,
	output logic [7:0]        rom_data,
	input  logic              rom_ack,
	input  logic [ROM_AW-1:0] core_rom_addr,
	output logic [ROM_AW-1:0] rom_rd_addr,
	output cart_info_t        cart
);

	logic              cart_sel_q;
	logic              byte_wr;
	logic [ROM_AW-1:0] addr_lo;

	assign byte_wr = dl.wr & cart_sel;
	assign addr_lo = dl.addr[ROM_AW-1:0];

	// ==================================================
	// Toggle write handshake
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_sel_q <= 1'b0;
			dl_wait    <= 1'b0;
			rom_req    <= 1'b0;
			rom_addr   <= '0;
		end else begin
			cart_sel_q <= cart_sel;
			if (byte_wr) begin
				dl_wait <= 1'b1;
				rom_req <= ~rom_req;    // New request
			end else if (dl_wait && rom_req == rom_ack) begin
				dl_wait  <= 1'b0;
				rom_addr <= rom_addr + 1'b1;
			end
			if (cart_sel && !cart_sel_q)
				rom_addr <= '0;    // Fresh image
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_wr)
			rom_data <= dl.data;
	end

	// ==================================================
	// Size masks and header detect
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart <= '0;
		end else begin
			if (byte_wr) begin
				cart.mask    <= (dl.addr == '0) ? '0 : cart.mask | addr_lo;
				cart.mask512 <= (dl.addr == 25'(HDR_BYTES)) ? '0
					: cart.mask512 | (addr_lo - ROM_AW'(HDR_BYTES));
				cart.gg      <= dl.index[4:0] == 5'(GG_INDEX);
			end
			// Host leaves addr at the byte count once the stream ends
			if (cart_sel_q && !cart_sel)
				cart.sz512 <= dl.addr[9];
		end
	end

	// Core read address, header skipped when present
	assign rom_rd_addr = cart.sz512 ? (core_rom_addr + ROM_AW'(HDR_BYTES)) & cart.mask512
		: core_rom_addr & cart.mask;

endmodule

// ==== src/cheat_loader.sv ====
module cheat_loader import sms_loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  dl_bus_t     dl,
	input  logic        cheat_sel,     // Cheat file download in progress
	output cheat_code_t cheat,
	output logic        cheat_valid
);

	logic       byte_wr;
	logic [1:0] field;
	logic [4:0] lane_lsb;

	assign byte_wr  = dl.wr & cheat_sel;
	assign field    = dl.addr[3:2];
	assign lane_lsb = {dl.addr[1:0], 3'b000};    // Little endian within a word

	// Record layout is flags, address, compare, replace
	always_ff @(posedge clk_sys) begin
		if (byte_wr) begin
			case (field)
				2'd0: cheat.flags[lane_lsb +: 8]   <= dl.data;
				2'd1: cheat.address[lane_lsb +: 8] <= dl.data;
				2'd2: cheat.compare[lane_lsb +: 8] <= dl.data;
				default: cheat.replace[lane_lsb +: 8] <= dl.data;
			endcase
		end
	end

	// Last byte of the record closes it
	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= byte_wr && dl.addr[3:0] == 4'hF;
	end

endmodule

// ==== src/clock_enable_gen.sv ====
module clock_enable_gen import sms_loader_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	localparam int CNT_W = $clog2(CE_PERIOD);

	logic [CNT_W-1:0] cnt;

	// Enables come out one cycle after the count that selects them
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt    <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			cnt    <= (cnt == CNT_W'(CE_PERIOD - 1)) ? '0 : cnt + 1'b1;
			ce_sp  <= cnt[0];    // Half rate
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;
			case (cnt)
				CNT_W'(4), CNT_W'(14): begin
					ce_vdp <= 1'b1;
				end
				CNT_W'(9): begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
					ce_cpu <= 1'b1;
				end
				CNT_W'(19), CNT_W'(29): begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				CNT_W'(24): begin
					// CPU phase sits late in the second half
					ce_vdp <= 1'b1;
					ce_cpu <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== src/nvram_dpram.sv ====
module nvram_dpram import sms_loader_pkg::*; (
	input  logic                clk_sys,
	input  logic [NVRAM_AW-1:0] a_addr,
	input  logic                a_we,
	input  logic [7:0]          a_d,
	output logic [7:0]          a_q,
	input  logic [NVRAM_AW-1:0] b_addr,
	input  logic                b_we,
	input  logic [7:0]          b_d,
	output logic [7:0]          b_q
);

	logic [7:0] mem [2**NVRAM_AW];

	// Both ports on clk_sys, reads return old data on a collision
	always_ff @(posedge clk_sys) begin
		if (a_we)
			mem[a_addr] <= a_d;
		if (b_we)
			mem[b_addr] <= b_d;
		a_q <= mem[a_addr];
		b_q <= mem[b_addr];
	end

endmodule

// ==== src/sms_loader_pkg.sv ====
package sms_loader_pkg;

	// ==================================================
	// Sizes and codes
	// ==================================================
	localparam int CE_PERIOD   = 30;     // clk_sys cycles per enable pattern
	localparam int ROM_AW      = 22;
	localparam int HDR_BYTES   = 512;    // Optional copier header
	localparam logic [7:0] CHEAT_INDEX = 8'hFF;
	localparam int GG_INDEX    = 2;      // Low five index bits of a handheld image
	localparam int SECTOR_AW   = 9;
	localparam int BK_SECTORS  = 64;     // Sectors per backup file
	localparam int LBA_W       = 6;
	localparam int NVRAM_AW    = 15;

	// ==================================================
	// Bundles
	// ==================================================

	// Host download stream
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_bus_t;

	typedef struct packed {
		logic [ROM_AW-1:0] mask;
		logic [ROM_AW-1:0] mask512;
		logic              sz512;    // Image carries the header
		logic              gg;       // Handheld mode
	} cart_info_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Byte lane from the SD block buffer
	typedef struct packed {
		logic                 ack;
		logic [SECTOR_AW-1:0] buff_addr;
		logic                 buff_wr;
		logic [7:0]           buff_dout;
	} sd_buf_t;

	typedef struct packed {
		logic [NVRAM_AW-1:0] addr;
		logic                we;
		logic [7:0]          d;
	} nv_port_t;

endpackage

// ==== src/sms_loader_top.sv ====
module sms_loader_top import sms_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  dl_bus_t           dl,
	output logic              dl_wait,
	output logic              rom_req,
	output logic [ROM_AW-1:0] rom_addr,
	output logic [7:0]        rom_data,
	input  logic              rom_ack,
	input  logic [ROM_AW-1:0] core_rom_addr,
	output logic [ROM_AW-1:0] rom_rd_addr,
	output cart_info_t        cart,
	output cheat_code_t       cheat,
	output logic              cheat_valid,
	output logic              ce_cpu,
	output logic              ce_vdp,
	output logic              ce_pix,
	output logic              ce_sp,
	input  nv_port_t          nv,
	output logic [7:0]        nv_q,
	input  sd_buf_t           sd,
	output logic [LBA_W-1:0]  sd_lba,
	output logic              sd_rd,
	output logic              sd_wr,
	output logic [7:0]        sd_buff_din,
	input  logic              bk_load,
	input  logic              bk_save,
	input  logic              autosave,
	input  logic              osd_open,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic              img_size_nz,
	output logic              bk_state,
	output logic              bk_loading,
	output logic              bk_pending,
	output logic              core_reset
);

	logic cheat_dl, cart_dl;

	// Index 0xFF carries cheats, everything else is a cartridge
	assign cheat_dl = dl.download & (dl.index == CHEAT_INDEX);
	assign cart_dl  = dl.download & (dl.index != CHEAT_INDEX);

	// Core held while the image or its save RAM is being filled
	assign core_reset = reset | cart_dl | bk_loading;

	clock_enable_gen ce_gen_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_loader cart_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl            (dl),
		.cart_sel      (cart_dl),
		.dl_wait       (dl_wait),
		.rom_req       (rom_req),
		.rom_addr      (rom_addr),
		.rom_data      (rom_data),
		.rom_ack       (rom_ack),
		.core_rom_addr (core_rom_addr),
		.rom_rd_addr   (rom_rd_addr),
		.cart          (cart)
	);

	cheat_loader cheat_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.cheat_sel   (cheat_dl),
		.cheat       (cheat),
		.cheat_valid (cheat_valid)
	);

	backup_ram_ctrl bk_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_dl      (cart_dl),
		.nv           (nv),
		.nv_q         (nv_q),
		.sd           (sd),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_buff_din  (sd_buff_din),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.bk_state     (bk_state),
		.bk_loading   (bk_loading),
		.bk_pending   (bk_pending)
	);

endmodule

// ==== tb.f ====
src/sms_loader_pkg.sv
src/clock_enable_gen.sv
src/cart_loader.sv
src/cheat_loader.sv
src/nvram_dpram.sv
src/backup_ram_ctrl.sv
src/sms_loader_top.sv
dv/sms_loader_asserts.sv
dv/sms_loader_tb.sv
